//--- hdl/eeprom_pkg.sv
package eeprom_pkg;

    // memory geometry, 2 KB part
    localparam int ADDR_W  = 11;
    localparam int BYTE_W  = 8;
    localparam int BLOCK_W = 3;   // address bits carried in the control byte

    localparam int CMD_DEPTH = 2;
    localparam int PTR_W     = $clog2(CMD_DEPTH);

    // clk cycles per quarter of an scl period
    localparam int SCL_QUARTER = 4;
    localparam int QCNT_W      = $clog2(SCL_QUARTER);

    localparam logic [3:0] CTRL_PREFIX = 4'b1010;

    typedef logic [ADDR_W-1:0] eeprom_addr_t;
    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [PTR_W-1:0]  qptr_t;
    typedef logic [PTR_W:0]    qcount_t;
    typedef logic [QCNT_W-1:0] qcnt_t;
    typedef logic [3:0]        bit_idx_t;   // 8 data slots plus ack slot

    typedef enum logic {
        OP_WRITE,
        OP_READ
    } eeprom_op_e;

    typedef struct packed {
        eeprom_op_e   op;
        eeprom_addr_t addr;
        byte_t        data;   // unused for reads
    } cmd_t;

    typedef struct packed {
        eeprom_op_e op;
        byte_t      rdata;
        logic       nack;
    } rsp_t;

    typedef enum logic [2:0] {
        STEP_START,
        STEP_RESTART,
        STEP_WRITE_BYTE,
        STEP_READ_BYTE,
        STEP_STOP
    } step_kind_e;

    typedef struct packed {
        step_kind_e kind;
        byte_t      wdata;
        logic       last;
    } step_t;

    // command sequencer
    typedef enum logic [3:0] {
        DS_IDLE,
        DS_START,
        DS_CTRL_W,
        DS_ADDR,
        DS_DATA,
        DS_RESTART,
        DS_CTRL_R,
        DS_READ,
        DS_STOP
    } dec_state_e;

    // quarters of one bit slot on the bus
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_Q0,
        PH_Q1,
        PH_Q2,
        PH_Q3
    } eng_phase_e;

endpackage

//--- hdl/eeprom_cmd_decode.sv
`timescale 1ns/1ps
module eeprom_cmd_decode
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  eeprom_pkg::cmd_t       cmd,
    input  logic                   cmd_valid,
    input  logic                   step_done,
    output logic                   cmd_credit,
    output eeprom_pkg::step_t      step,
    output logic                   step_valid,
    output eeprom_pkg::eeprom_op_e cur_op
);

    eeprom_pkg::cmd_t       queue [eeprom_pkg::CMD_DEPTH];
    eeprom_pkg::qptr_t      wr_ptr;
    eeprom_pkg::qptr_t      rd_ptr;
    eeprom_pkg::qcount_t    count;
    eeprom_pkg::cmd_t       cur_cmd;
    eeprom_pkg::dec_state_e state;
    eeprom_pkg::byte_t      ctrl_w;
    eeprom_pkg::byte_t      ctrl_r;
    logic                   pop;

    function automatic eeprom_pkg::qptr_t next_ptr(input eeprom_pkg::qptr_t ptr);
        if (ptr == eeprom_pkg::qptr_t'(eeprom_pkg::CMD_DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // step list: write ends after the data byte, read goes on with a restart
    function automatic eeprom_pkg::dec_state_e seq_next(input eeprom_pkg::dec_state_e cur,
                                                        input eeprom_pkg::eeprom_op_e op);
        case (cur)
            eeprom_pkg::DS_START:   return eeprom_pkg::DS_CTRL_W;
            eeprom_pkg::DS_CTRL_W:  return eeprom_pkg::DS_ADDR;
            eeprom_pkg::DS_ADDR:
            begin
                if (op == eeprom_pkg::OP_READ)
                begin
                    return eeprom_pkg::DS_RESTART;
                end
                return eeprom_pkg::DS_DATA;
            end
            eeprom_pkg::DS_DATA:    return eeprom_pkg::DS_STOP;
            eeprom_pkg::DS_RESTART: return eeprom_pkg::DS_CTRL_R;
            eeprom_pkg::DS_CTRL_R:  return eeprom_pkg::DS_READ;
            eeprom_pkg::DS_READ:    return eeprom_pkg::DS_STOP;
            default:                return eeprom_pkg::DS_IDLE;
        endcase
    endfunction

    assign pop        = (state == eeprom_pkg::DS_IDLE) && (count != '0);
    assign cmd_credit = pop;   // slot frees on pop
    assign step_valid = (state != eeprom_pkg::DS_IDLE);
    assign cur_op     = cur_cmd.op;

    // device code, block bits, r/w bit
    assign ctrl_w = {eeprom_pkg::CTRL_PREFIX,
                     cur_cmd.addr[eeprom_pkg::ADDR_W-1 -: eeprom_pkg::BLOCK_W], 1'b0};
    assign ctrl_r = {eeprom_pkg::CTRL_PREFIX,
                     cur_cmd.addr[eeprom_pkg::ADDR_W-1 -: eeprom_pkg::BLOCK_W], 1'b1};

    always_ff @(posedge CLK)
    begin
        if (cmd_valid)
        begin
            queue[wr_ptr] <= cmd;
        end
        if (pop)
        begin
            cur_cmd <= queue[rd_ptr];
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            state  <= eeprom_pkg::DS_IDLE;
        end
        else
        begin
            if (cmd_valid)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + eeprom_pkg::qcount_t'(cmd_valid) - eeprom_pkg::qcount_t'(pop);

            if (state == eeprom_pkg::DS_IDLE)
            begin
                if (pop)
                begin
                    state <= eeprom_pkg::DS_START;
                end
            end
            else if (step_done)
            begin
                state <= seq_next(state, cur_cmd.op);
            end
        end
    end

    always_comb
    begin
        step      = '0;
        step.kind = eeprom_pkg::STEP_START;
        case (state)
            eeprom_pkg::DS_CTRL_W:
            begin
                step.kind  = eeprom_pkg::STEP_WRITE_BYTE;
                step.wdata = ctrl_w;
            end
            eeprom_pkg::DS_ADDR:
            begin
                step.kind  = eeprom_pkg::STEP_WRITE_BYTE;
                step.wdata = cur_cmd.addr[eeprom_pkg::BYTE_W-1:0];
            end
            eeprom_pkg::DS_DATA:
            begin
                step.kind  = eeprom_pkg::STEP_WRITE_BYTE;
                step.wdata = cur_cmd.data;
            end
            eeprom_pkg::DS_RESTART: step.kind = eeprom_pkg::STEP_RESTART;
            eeprom_pkg::DS_CTRL_R:
            begin
                step.kind  = eeprom_pkg::STEP_WRITE_BYTE;
                step.wdata = ctrl_r;
            end
            eeprom_pkg::DS_READ:    step.kind = eeprom_pkg::STEP_READ_BYTE;
            eeprom_pkg::DS_STOP:
            begin
                step.kind = eeprom_pkg::STEP_STOP;
                step.last = 1'b1;
            end
            default:                step.kind = eeprom_pkg::STEP_START;
        endcase
    end

endmodule

//--- hdl/i2c_bit_engine.sv
`timescale 1ns/1ps
module i2c_bit_engine
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  eeprom_pkg::step_t    step,
    input  logic                 step_valid,
    input  logic                 sda_in,
    output logic                 step_done,
    output logic                 step_ack,
    output eeprom_pkg::byte_t    step_rdata,
    output logic                 scl,
    output logic                 sda_oe
);

    eeprom_pkg::eng_phase_e phase;
    eeprom_pkg::eng_phase_e phase_nxt;
    eeprom_pkg::qcnt_t      qcnt;
    eeprom_pkg::bit_idx_t   slot;
    eeprom_pkg::bit_idx_t   last_slot;
    eeprom_pkg::step_kind_e kind_q;
    eeprom_pkg::byte_t      shreg;
    logic                   start;
    logic                   qtick;

    // start holds scl high throughout, every other step pulses it
    function automatic logic scl_level(input eeprom_pkg::step_kind_e kind,
                                       input eeprom_pkg::eng_phase_e ph);
        if (kind == eeprom_pkg::STEP_START)
        begin
            return 1'b1;
        end
        return (ph == eeprom_pkg::PH_Q2) || (ph == eeprom_pkg::PH_Q3);
    endfunction

    // pull-down level on entry to quarter ph, q0 keeps the previous level
    function automatic logic oe_level(input eeprom_pkg::step_kind_e kind,
                                      input eeprom_pkg::eng_phase_e ph,
                                      input eeprom_pkg::bit_idx_t   bit_slot,
                                      input logic                   msb,
                                      input logic                   cur);
        logic lvl;
        lvl = cur;
        case (kind)
            eeprom_pkg::STEP_START:
                lvl = (ph == eeprom_pkg::PH_Q2) || (ph == eeprom_pkg::PH_Q3);
            eeprom_pkg::STEP_RESTART:
            begin
                if (ph == eeprom_pkg::PH_Q1 || ph == eeprom_pkg::PH_Q2)
                    lvl = 1'b0;   // release while scl low
                else if (ph == eeprom_pkg::PH_Q3)
                    lvl = 1'b1;
            end
            eeprom_pkg::STEP_STOP:
            begin
                if (ph == eeprom_pkg::PH_Q1 || ph == eeprom_pkg::PH_Q2)
                    lvl = 1'b1;
                else if (ph == eeprom_pkg::PH_Q3)
                    lvl = 1'b0;   // rising with scl high
            end
            eeprom_pkg::STEP_WRITE_BYTE:
            begin
                if (ph == eeprom_pkg::PH_Q1)
                    lvl = (bit_slot < eeprom_pkg::bit_idx_t'(eeprom_pkg::BYTE_W)) ? ~msb : 1'b0;
            end
            eeprom_pkg::STEP_READ_BYTE:
            begin
                if (ph == eeprom_pkg::PH_Q1)
                    lvl = 1'b0;   // slave drives, nack on last slot
            end
            default:
                lvl = cur;
        endcase
        return lvl;
    endfunction

    assign start = (phase == eeprom_pkg::PH_IDLE) && step_valid && !step_done;
    assign qtick = (phase != eeprom_pkg::PH_IDLE) &&
                   (qcnt == eeprom_pkg::qcnt_t'(eeprom_pkg::SCL_QUARTER - 1));

    assign last_slot = (kind_q == eeprom_pkg::STEP_WRITE_BYTE ||
                        kind_q == eeprom_pkg::STEP_READ_BYTE) ?
                       eeprom_pkg::bit_idx_t'(eeprom_pkg::BYTE_W) : '0;

    assign step_rdata = shreg;

    always_comb
    begin
        case (phase)
            eeprom_pkg::PH_Q0: phase_nxt = eeprom_pkg::PH_Q1;
            eeprom_pkg::PH_Q1: phase_nxt = eeprom_pkg::PH_Q2;
            eeprom_pkg::PH_Q2: phase_nxt = eeprom_pkg::PH_Q3;
            eeprom_pkg::PH_Q3:
                phase_nxt = (slot == last_slot) ? eeprom_pkg::PH_IDLE : eeprom_pkg::PH_Q0;
            default:           phase_nxt = eeprom_pkg::PH_IDLE;
        endcase
    end

    // shift register, msb first both ways
    always_ff @(posedge CLK)
    begin
        if (start)
        begin
            kind_q <= step.kind;
            shreg  <= step.wdata;
        end
        else if (qtick)
        begin
            if (phase == eeprom_pkg::PH_Q2 && kind_q == eeprom_pkg::STEP_READ_BYTE &&
                slot < eeprom_pkg::bit_idx_t'(eeprom_pkg::BYTE_W))
            begin
                shreg <= {shreg[eeprom_pkg::BYTE_W-2:0], sda_in};
            end
            else if (phase == eeprom_pkg::PH_Q3 && kind_q == eeprom_pkg::STEP_WRITE_BYTE)
            begin
                shreg <= {shreg[eeprom_pkg::BYTE_W-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase     <= eeprom_pkg::PH_IDLE;
            qcnt      <= '0;
            slot      <= '0;
            scl       <= 1'b1;   // bus idle
            sda_oe    <= 1'b0;
            step_done <= 1'b0;
            step_ack  <= 1'b0;
        end
        else
        begin
            step_done <= 1'b0;
            if (start)
            begin
                phase    <= eeprom_pkg::PH_Q0;
                qcnt     <= '0;
                slot     <= '0;
                step_ack <= 1'b0;
                scl      <= scl_level(step.kind, eeprom_pkg::PH_Q0);
                sda_oe   <= oe_level(step.kind, eeprom_pkg::PH_Q0, '0,
                                     step.wdata[eeprom_pkg::BYTE_W-1], sda_oe);
            end
            else if (qtick)
            begin
                qcnt  <= '0;
                phase <= phase_nxt;
                // ack sampled mid high phase, low means acknowledged
                if (phase == eeprom_pkg::PH_Q2 && kind_q == eeprom_pkg::STEP_WRITE_BYTE &&
                    slot == last_slot)
                begin
                    step_ack <= ~sda_in;
                end
                if (phase == eeprom_pkg::PH_Q3)
                begin
                    slot <= slot + 1'b1;
                end
                if (phase_nxt == eeprom_pkg::PH_IDLE)
                begin
                    step_done <= 1'b1;   // pins hold until next step
                end
                else
                begin
                    scl    <= scl_level(kind_q, phase_nxt);
                    sda_oe <= oe_level(kind_q, phase_nxt, slot,
                                       shreg[eeprom_pkg::BYTE_W-1], sda_oe);
                end
            end
            else if (phase != eeprom_pkg::PH_IDLE)
            begin
                qcnt <= qcnt + 1'b1;
            end
        end
    end

endmodule

//--- hdl/eeprom_result.sv
`timescale 1ns/1ps
module eeprom_result
(
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   step_done,
    input  logic                   step_ack,
    input  eeprom_pkg::byte_t      step_rdata,
    input  eeprom_pkg::step_kind_e step_kind,
    input  logic                   step_last,
    input  eeprom_pkg::eeprom_op_e cur_op,
    output eeprom_pkg::rsp_t       rsp,
    output logic                   rsp_valid
);

    logic              nack_q;
    logic              nack_nxt;
    eeprom_pkg::byte_t rdata_q;
    eeprom_pkg::byte_t rdata_nxt;

    // include the finishing step itself
    assign nack_nxt = nack_q ||
                      (step_kind == eeprom_pkg::STEP_WRITE_BYTE && !step_ack);
    assign rdata_nxt = (step_kind == eeprom_pkg::STEP_READ_BYTE) ? step_rdata : rdata_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            nack_q    <= 1'b0;
            rdata_q   <= '0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= step_done && step_last;
            if (step_done)
            begin
                if (step_last)
                begin
                    nack_q  <= 1'b0;   // ready for next command
                    rdata_q <= '0;
                end
                else
                begin
                    nack_q  <= nack_nxt;
                    rdata_q <= rdata_nxt;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (step_done && step_last)
        begin
            rsp.op    <= cur_op;
            rsp.rdata <= (cur_op == eeprom_pkg::OP_READ) ? rdata_nxt : '0;
            rsp.nack  <= nack_nxt;
        end
    end

endmodule

//--- hdl/eeprom_ctrl_top.sv
`timescale 1ns/1ps
module eeprom_ctrl_top
(
    input  logic              CLK,
    input  logic              RESET,
    input  eeprom_pkg::cmd_t  cmd,
    input  logic              cmd_valid,
    input  logic              sda_in,
    output logic              cmd_credit,
    output eeprom_pkg::rsp_t  rsp,
    output logic              rsp_valid,
    output logic              scl,
    output logic              sda_oe
);

    eeprom_pkg::step_t      step;
    logic                   step_valid;
    logic                   step_done;
    logic                   step_ack;
    eeprom_pkg::byte_t      step_rdata;
    eeprom_pkg::eeprom_op_e cur_op;

    eeprom_cmd_decode i_decode
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .step_done  (step_done),
        .cmd_credit (cmd_credit),
        .step       (step),
        .step_valid (step_valid),
        .cur_op     (cur_op)
    );

    i2c_bit_engine i_engine
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .step       (step),
        .step_valid (step_valid),
        .sda_in     (sda_in),
        .step_done  (step_done),
        .step_ack   (step_ack),
        .step_rdata (step_rdata),
        .scl        (scl),
        .sda_oe     (sda_oe)
    );

    // kind and last still show the finishing step during step_done
    eeprom_result i_result
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .step_done  (step_done),
        .step_ack   (step_ack),
        .step_rdata (step_rdata),
        .step_kind  (step.kind),
        .step_last  (step.last),
        .cur_op     (cur_op),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid)
    );

endmodule

//--- test/eeprom_model.sv
`timescale 1ns/1ps
module eeprom_model
(
    input  logic CLK,
    input  logic scl,
    input  logic sda,
    input  logic refuse,        // stay silent, no acknowledges
    output logic sda_pull,      // 1 pulls the line low
    output int   start_count,
    output int   stop_count
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_RX,
        M_ACK,
        M_TX,
        M_TX_ACK
    } model_state_e;

    logic [7:0]   mem [2048];
    model_state_e state;
    logic         scl_q;
    logic         sda_q;
    logic [7:0]   shreg;
    logic [7:0]   tx_byte;
    int           bit_cnt;
    int           byte_idx;
    logic         rw;
    logic [10:0]  ptr;

    initial
    begin
        state       = M_IDLE;
        scl_q       = 1'b1;
        sda_q       = 1'b1;
        shreg       = '0;
        tx_byte     = '0;
        bit_cnt     = 0;
        byte_idx    = 0;
        rw          = 1'b0;
        ptr         = '0;
        sda_pull    = 1'b0;
        start_count = 0;
        stop_count  = 0;
    end

    // bus sampled once per CLK, edges found against the previous sample
    always @(posedge CLK)
    begin
        if (scl && scl_q && sda_q && !sda)
        begin
            start_count <= start_count + 1;
            state    = M_RX;
            bit_cnt  = 0;
            byte_idx = 0;
        end
        else if (scl && scl_q && !sda_q && sda)
        begin
            stop_count <= stop_count + 1;
            state = M_IDLE;
        end
        else if (scl && !scl_q && state == M_RX)
        begin
            shreg   = {shreg[6:0], sda};   // msb first
            bit_cnt = bit_cnt + 1;
        end
        else if (!scl && scl_q)
        begin
            case (state)
                M_RX:
                begin
                    if (bit_cnt == 8)
                    begin
                        if (refuse || (byte_idx == 0 && shreg[7:4] != 4'b1010))
                        begin
                            state = M_IDLE;
                        end
                        else
                        begin
                            if (byte_idx == 0)
                            begin
                                rw  = shreg[0];
                                ptr = {shreg[3:1], ptr[7:0]};   // block bits
                            end
                            else if (byte_idx == 1)
                                ptr = {ptr[10:8], shreg};
                            else
                                mem[ptr] = shreg;
                            byte_idx = byte_idx + 1;
                            sda_pull <= 1'b1;
                            state = M_ACK;
                        end
                    end
                end
                M_ACK:
                begin
                    bit_cnt = 0;
                    if (rw)
                    begin
                        tx_byte = mem[ptr];
                        sda_pull <= ~tx_byte[7];
                        state = M_TX;
                    end
                    else
                    begin
                        sda_pull <= 1'b0;
                        state = M_RX;
                    end
                end
                M_TX:
                begin
                    bit_cnt = bit_cnt + 1;
                    tx_byte = tx_byte << 1;
                    if (bit_cnt == 8)
                    begin
                        sda_pull <= 1'b0;   // master answers with nack
                        state = M_TX_ACK;
                    end
                    else
                        sda_pull <= ~tx_byte[7];
                end
                default:
                    state = state;
            endcase
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

//--- test/tb_eeprom_ctrl.sv
`timescale 1ns/1ps
module tb_eeprom_ctrl;

    localparam int CLK_NS     = 8;
    localparam int N_CMDS     = 40;
    localparam int BIT_CYCLES = 4 * eeprom_pkg::SCL_QUARTER;
    // four bytes of nine bits, three short steps, handshake gaps
    localparam int READ_CYCLES = 4 * 9 * BIT_CYCLES + 3 * BIT_CYCLES + 32;

    typedef struct packed {
        eeprom_pkg::rsp_t rsp;
        int               starts;   // bus totals once this command is done
        int               stops;
    } expect_t;

    logic              CLK;
    logic              RESET;
    eeprom_pkg::cmd_t  cmd;
    logic              cmd_valid;
    logic              cmd_credit;
    eeprom_pkg::rsp_t  rsp;
    logic              rsp_valid;
    logic              scl;
    logic              sda_oe;
    logic              sda_line;
    logic              model_pull;
    logic              refuse;
    int                start_count;
    int                stop_count;

    eeprom_pkg::byte_t        exp_mem [2048];
    expect_t                  exp_q [$];
    eeprom_pkg::eeprom_addr_t addr_list [8];
    int                       issued;
    int                       credit_pulses;
    int                       rsp_count;
    int                       exp_starts;
    int                       exp_stops;
    logic [31:0]              rand_state;
    logic                     scl_prev;
    logic                     sda_prev;
    logic                     bus_check_en;
    logic                     any_cmd;

    assign sda_line = ~(sda_oe | model_pull);   // open drain with pull-up

    eeprom_ctrl_top i_dut
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .sda_in     (sda_line),
        .cmd_credit (cmd_credit),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid),
        .scl        (scl),
        .sda_oe     (sda_oe)
    );

    eeprom_model i_model
    (
        .CLK         (CLK),
        .scl         (scl),
        .sda         (sda_line),
        .refuse      (refuse),
        .sda_pull    (model_pull),
        .start_count (start_count),
        .stop_count  (stop_count)
    );

    task automatic fail_stop();
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // waits for a credit, then presents one command for one cycle
    task automatic issue(input eeprom_pkg::eeprom_op_e op,
                         input eeprom_pkg::eeprom_addr_t addr,
                         input eeprom_pkg::byte_t data);
        expect_t e;
        while (issued - credit_pulses >= eeprom_pkg::CMD_DEPTH)
        begin
            @(posedge CLK);
            #1;
        end
        e          = '0;
        e.rsp.op   = op;
        e.rsp.nack = refuse;
        if (op == eeprom_pkg::OP_WRITE)
        begin
            if (!refuse)
                exp_mem[addr] = data;
            exp_starts += 1;
        end
        else
        begin
            e.rsp.rdata = refuse ? 8'hff : exp_mem[addr];   // released line reads ones
            exp_starts += 2;
        end
        exp_stops += 1;
        e.starts = exp_starts;
        e.stops  = exp_stops;
        exp_q.push_back(e);
        cmd.op    = op;
        cmd.addr  = addr;
        cmd.data  = data;
        cmd_valid = 1'b1;
        any_cmd   = 1'b1;
        issued++;
        @(posedge CLK);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0)
        begin
            @(posedge CLK);
            #1;
        end
    endtask

    initial
    begin
        CLK = 1'b0;
        forever #(CLK_NS / 2) CLK = ~CLK;
    end

    initial
    begin
        #(N_CMDS * 2 * READ_CYCLES * CLK_NS + 200 * CLK_NS);
        $display("timeout: responses still missing after %0d commands issued", issued);
        fail_stop();
    end

    always @(posedge CLK)
    begin
        expect_t e;
        if (!RESET)
        begin
            // queue slots plus the one on the bus
            assert (issued - rsp_count <= eeprom_pkg::CMD_DEPTH + 1)
            else
            begin
                $display("more commands in flight than queue slots plus the one on the bus");
                fail_stop();
            end
            if (cmd_credit)
            begin
                assert (credit_pulses < issued)
                else
                begin
                    $display("credit returned with no accepted command left");
                    fail_stop();
                end
                credit_pulses++;
            end
            if (rsp_valid)
            begin
                assert (exp_q.size() > 0)
                else
                begin
                    $display("response arrived with no command outstanding");
                    fail_stop();
                end
                e = exp_q.pop_front();
                assert (rsp == e.rsp)
                else
                begin
                    $display("ERR rsp op/rdata/nack: got %h/%h/%h expected %h/%h/%h",
                             rsp.op, rsp.rdata, rsp.nack, e.rsp.op, e.rsp.rdata, e.rsp.nack);
                    fail_stop();
                end
                assert (start_count == e.starts && stop_count == e.stops)
                else
                begin
                    $display("ERR start_count/stop_count: got %h/%h expected %h/%h",
                             start_count, stop_count, e.starts, e.stops);
                    fail_stop();
                end
                rsp_count++;
            end
            if (bus_check_en)
            begin
                // only start and stop move data with clock high, counted above
                assert (!(scl != scl_prev && sda_line != sda_prev))
                else
                begin
                    $display("data line changed on a clock edge");
                    fail_stop();
                end
                if (!any_cmd)
                begin
                    assert (scl && !sda_oe && !cmd_credit && !rsp_valid)
                    else
                    begin
                        $display("ERR scl/sda_oe/cmd_credit/rsp_valid: %h/%h/%h/%h, want 1/0/0/0",
                                 scl, sda_oe, cmd_credit, rsp_valid);
                        fail_stop();
                    end
                end
            end
        end
        scl_prev = scl;
        sda_prev = sda_line;
    end

    initial
    begin
        eeprom_pkg::byte_t d;
        RESET         = 1'b1;
        cmd           = '0;
        cmd_valid     = 1'b0;
        refuse        = 1'b0;
        issued        = 0;
        credit_pulses = 0;
        rsp_count     = 0;
        exp_starts    = 0;
        exp_stops     = 0;
        any_cmd       = 1'b0;
        bus_check_en  = 1'b0;
        rand_state    = 32'h7250;
        repeat (2) @(posedge CLK);
        #1;
        RESET        = 1'b0;
        bus_check_en = 1'b1;
        repeat (20) @(posedge CLK);   // idle bus
        #1;

        for (int i = 0; i < 8; i++)
        begin
            rand_state   = lcg_next(rand_state);
            addr_list[i] = rand_state[26:16];
            rand_state   = lcg_next(rand_state);
            issue(eeprom_pkg::OP_WRITE, addr_list[i], rand_state[23:16]);
        end
        for (int i = 0; i < 8; i++)
            issue(eeprom_pkg::OP_READ, addr_list[i], '0);

        // same low byte in each of the eight blocks
        rand_state = lcg_next(rand_state);
        for (int b = 0; b < 8; b++)
        begin
            d = rand_state[7:0] ^ eeprom_pkg::byte_t'(b * 37);
            issue(eeprom_pkg::OP_WRITE, {3'(b), rand_state[23:16]}, d);
        end
        for (int b = 0; b < 8; b++)
            issue(eeprom_pkg::OP_READ, {3'(b), rand_state[23:16]}, '0);

        wait_drain();
        refuse = 1'b1;
        issue(eeprom_pkg::OP_WRITE, addr_list[0], ~rand_state[15:8]);
        issue(eeprom_pkg::OP_READ, addr_list[0], '0);
        issue(eeprom_pkg::OP_WRITE, addr_list[1], rand_state[15:8]);
        issue(eeprom_pkg::OP_READ, addr_list[1], '0);
        wait_drain();
        refuse = 1'b0;
        issue(eeprom_pkg::OP_READ, addr_list[0], '0);
        issue(eeprom_pkg::OP_READ, addr_list[1], '0);
        issue(eeprom_pkg::OP_WRITE, addr_list[2], rand_state[31:24]);
        issue(eeprom_pkg::OP_READ, addr_list[2], '0);

        wait_drain();
        repeat (4) @(posedge CLK);
        if (credit_pulses == issued && rsp_count == issued)
        begin
            $display("all tests passed");
            $finish;
        end
        else
        begin
            $display("credits %0d and responses %0d do not match %0d commands",
                     credit_pulses, rsp_count, issued);
            fail_stop();
        end
    end

endmodule

//--- vlog.f
hdl/eeprom_pkg.sv
hdl/eeprom_cmd_decode.sv
hdl/i2c_bit_engine.sv
hdl/eeprom_result.sv
hdl/eeprom_ctrl_top.sv
test/eeprom_model.sv
test/tb_eeprom_ctrl.sv

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_eeprom_ctrl -f vlog.f \
    && ./obj_dir/Vtb_eeprom_ctrl > sim.log 2>&1 \
    || echo "tests failed" >> sim.log
cat sim.log
! grep -q "tests failed" sim.log && grep -q "all tests passed" sim.log
